// File: hdl/uartBusPkg.sv
package uartBusPkg;

	////////////////////////////////////////////////////////////////////////////
	// Strobe timing of the UART chip's parallel bus
	////////////////////////////////////////////////////////////////////////////

	// Cycles rdn stays low, data captured in the last one
	localparam int ReadLowCycles = 2;

	// Cycles wrn stays low with data on the bus
	localparam int WriteLowCycles = 2;

	////////////////////////////////////////////////////////////////////////////
	// Bus types
	////////////////////////////////////////////////////////////////////////////

	// One data byte on the chip bus
	typedef logic [7:0] busByte_t;

	// Status lines driven by the chip
	typedef struct packed {
		// Received byte waiting
		logic dataReady;
		// Transmit buffer empty
		logic tbre;
		// Transmit shift register empty
		logic tsre;
	} chipStatus_t;

endpackage

// File: hdl/echoPkg.sv
package echoPkg;

	import uartBusPkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Pipeline payloads
	////////////////////////////////////////////////////////////////////////////

	// Received byte tagged with its arrival order
	typedef struct packed {
		busByte_t    data;
		logic [15:0] seq;
	} rxItem_t;

	// Byte ready to go back out
	typedef struct packed {
		busByte_t data;
	} txItem_t;

	// Entries per stage FIFO
	localparam int FifoDepth = 4;

	////////////////////////////////////////////////////////////////////////////
	// Wishbone classic bundles and register map
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		logic [1:0] adr;
		logic [7:0] dat;
	} wbReq_t;

	typedef struct packed {
		logic       ack;
		logic [7:0] dat;
	} wbRsp_t;

	localparam logic [1:0] RegIncr    = 2'd0;
	localparam logic [1:0] RegRxCount = 2'd1;
	localparam logic [1:0] RegTxCount = 2'd2;

	// Increment after reset
	localparam logic [7:0] IncrReset = 8'd1;

endpackage

// File: hdl/uartReader.sv
`timescale 1ns/10ps

module uartReader import uartBusPkg::*, echoPkg::*; (
	input  logic        CLK,
	input  logic        RST,
	input  chipStatus_t status,
	input  busByte_t    busIn,
	output logic        rdn,
	input  logic        full,
	output logic        push,
	output rxItem_t     item,
	output logic        rxPulse
);

	typedef enum logic [1:0] {
		Idle,
		Strobe,
		Deliver
	} readState_t;

	readState_t  state;
	logic [3:0]  lowCnt;
	logic        lastLow;
	busByte_t    capture;
	logic [15:0] seqNum;

	assign lastLow = (state == Strobe) && (int'(lowCnt) == ReadLowCycles - 1);

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			state  <= Idle;
			rdn    <= 1'b1;
			lowCnt <= '0;
			seqNum <= '0;
		end else begin
			case (state)
				Idle: begin
					// Chip keeps dataReady up while we are blocked
					if (status.dataReady && !full) begin
						state  <= Strobe;
						rdn    <= 1'b0;
						lowCnt <= '0;
					end
				end
				Strobe: begin
					if (lastLow) begin
						state <= Deliver;
						rdn   <= 1'b1;
					end else begin
						lowCnt <= lowCnt + 4'd1;
					end
				end
				Deliver: begin
					// rdn high for this cycle before dataReady is looked at again
					state  <= Idle;
					seqNum <= seqNum + 16'd1;
				end
				default: state <= Idle;
			endcase
		end
	end

	// Byte sampled at the end of the last low cycle
	always_ff @(posedge CLK) begin
		if (lastLow) begin
			capture <= busIn;
		end
	end

	assign push    = (state == Deliver);
	assign rxPulse = (state == Deliver);
	assign item    = '{data: capture, seq: seqNum};

endmodule

// File: hdl/stageFifo.sv
`timescale 1ns/10ps

module stageFifo import echoPkg::*; #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     CLK,
	input  logic     RST,
	input  logic     push,
	input  payload_t din,
	output logic     full,
	input  logic     pop,
	output payload_t dout,
	output logic     empty
);

	payload_t mem [FifoDepth];

	logic [$clog2(FifoDepth)-1:0] wrPtr;
	logic [$clog2(FifoDepth)-1:0] rdPtr;
	logic [$clog2(FifoDepth+1)-1:0] count;
	logic doPush;
	logic doPop;

	assign doPush = push && !full;
	assign doPop  = pop && !empty;

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= (int'(wrPtr) == FifoDepth - 1) ? '0 : wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= (int'(rdPtr) == FifoDepth - 1) ? '0 : rdPtr + 1'b1;
			end
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (doPush) begin
			mem[wrPtr] <= din;
		end
	end

	// Head entry is valid whenever empty is low
	assign dout  = mem[rdPtr];
	assign full  = (int'(count) == FifoDepth);
	assign empty = (count == '0);

endmodule

// File: hdl/echoTransform.sv
`timescale 1ns/10ps

module echoTransform import uartBusPkg::*, echoPkg::*; (
	input  logic     CLK,
	input  logic     RST,
	input  logic     empty,
	output logic     pop,
	input  rxItem_t  inItem,
	input  logic     full,
	output logic     push,
	output txItem_t  outItem,
	input  busByte_t incr
);

	// One result register between the two FIFOs
	txItem_t holdItem;
	logic    holdValid;

	// Register drains into fifo B whenever it has room
	assign push = holdValid && !full;

	// Refill when the register is free or being emptied this cycle
	assign pop = !empty && (!holdValid || push);

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			holdValid <= 1'b0;
		end else if (pop) begin
			holdValid <= 1'b1;
		end else if (push) begin
			holdValid <= 1'b0;
		end
	end

	// Sum wraps at 256, sequence tag ends here
	always_ff @(posedge CLK) begin
		if (pop) begin
			holdItem.data <= inItem.data + incr;
		end
	end

	assign outItem = holdItem;

endmodule

// File: hdl/echoRegs.sv
`timescale 1ns/10ps

module echoRegs import uartBusPkg::*, echoPkg::*; (
	input  logic     CLK,
	input  logic     RST,
	input  wbReq_t   wbIn,
	output wbRsp_t   wbOut,
	input  logic     rxPulse,
	input  logic     txPulse,
	output busByte_t incr
);

	logic       ack;
	logic       access;
	logic [7:0] rdData;
	logic [7:0] rxCount;
	logic [7:0] txCount;

	// New cycle only when no ack went out last cycle
	assign access = wbIn.cyc && wbIn.stb && !ack;

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			ack  <= 1'b0;
			incr <= IncrReset;
		end else begin
			ack <= access;
			// Counter addresses are read only
			if (access && wbIn.we && wbIn.adr == RegIncr) begin
				incr <= wbIn.dat;
			end
		end
	end

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			rxCount <= '0;
			txCount <= '0;
		end else begin
			if (rxPulse) rxCount <= rxCount + 8'd1;
			if (txPulse) txCount <= txCount + 8'd1;
		end
	end

	// Read data registered alongside ack
	always_ff @(posedge CLK) begin
		if (access) begin
			case (wbIn.adr)
				RegIncr:    rdData <= incr;
				RegRxCount: rdData <= rxCount;
				RegTxCount: rdData <= txCount;
				default:    rdData <= 8'd0;
			endcase
		end
	end

	assign wbOut = '{ack: ack, dat: rdData};

endmodule

// File: hdl/uartWriter.sv
`timescale 1ns/10ps

module uartWriter import uartBusPkg::*, echoPkg::*; (
	input  logic        CLK,
	input  logic        RST,
	input  logic        empty,
	output logic        pop,
	input  txItem_t     item,
	input  chipStatus_t status,
	output busByte_t    busOut,
	output logic        busOe,
	output logic        wrn,
	output logic        txPulse
);

	typedef enum logic [1:0] {
		Idle,
		Strobe,
		WaitTbre,
		WaitTsre
	} writeState_t;

	writeState_t state;
	logic [3:0]  lowCnt;
	busByte_t    outByte;

	// Take a byte only when the chip is free
	assign pop = (state == Idle) && !empty;

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			state   <= Idle;
			wrn     <= 1'b1;
			busOe   <= 1'b0;
			lowCnt  <= '0;
			txPulse <= 1'b0;
		end else begin
			txPulse <= 1'b0;
			case (state)
				Idle: begin
					if (pop) begin
						state  <= Strobe;
						wrn    <= 1'b0;
						busOe  <= 1'b1;
						lowCnt <= '0;
					end
				end
				Strobe: begin
					if (int'(lowCnt) == WriteLowCycles - 1) begin
						state <= WaitTbre;
						wrn   <= 1'b1;
						busOe <= 1'b0;
					end else begin
						lowCnt <= lowCnt + 4'd1;
					end
				end
				// Buffer first, then shift register
				WaitTbre: if (status.tbre) state <= WaitTsre;
				WaitTsre: begin
					if (status.tsre) begin
						state   <= Idle;
						txPulse <= 1'b1;
					end
				end
				default: state <= Idle;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (pop) begin
			outByte <= item.data;
		end
	end

	assign busOut = outByte;

endmodule

// File: hdl/echoTop.sv
`timescale 1ns/10ps

module echoTop import uartBusPkg::*, echoPkg::*; (
	input  logic        CLK,
	input  logic        RST,
	input  chipStatus_t status,
	input  busByte_t    busIn,
	output busByte_t    busOut,
	output logic        busOe,
	output logic        rdn,
	output logic        wrn,
	input  wbReq_t      wbIn,
	output wbRsp_t      wbOut
);

	////////////////////////////////////////////////////////////////////////////
	// Links between stages
	////////////////////////////////////////////////////////////////////////////

	// Reader to fifo A to transform
	logic    rxPush, rxFull, rxPop, rxEmpty;
	rxItem_t rxIn, rxHead;

	// Transform to fifo B to writer
	logic    txPush, txFull, txPop, txEmpty;
	txItem_t txIn, txHead;

	busByte_t incr;
	logic     rxPulse, txPulse;

	// The chip has one data bus, so read and write strobes never overlap
	chipStatus_t readStatus;
	logic        writeEmpty;

	// Writer starts only while rdn is high
	assign writeEmpty = txEmpty || !rdn;

	// Reader holds off during a write strobe and when one starts
	assign readStatus = '{
		dataReady: status.dataReady && wrn && !txPop,
		tbre:      status.tbre,
		tsre:      status.tsre
	};

	////////////////////////////////////////////////////////////////////////////
	// Pipeline
	////////////////////////////////////////////////////////////////////////////

	uartReader reader (
		.CLK(CLK), .RST(RST), .status(readStatus), .busIn(busIn), .rdn(rdn),
		.full(rxFull), .push(rxPush), .item(rxIn), .rxPulse(rxPulse)
	);

	stageFifo #(.payload_t(rxItem_t)) rxFifo (
		.CLK(CLK), .RST(RST), .push(rxPush), .din(rxIn), .full(rxFull),
		.pop(rxPop), .dout(rxHead), .empty(rxEmpty)
	);

	echoTransform transform (
		.CLK(CLK), .RST(RST), .empty(rxEmpty), .pop(rxPop), .inItem(rxHead),
		.full(txFull), .push(txPush), .outItem(txIn), .incr(incr)
	);

	stageFifo #(.payload_t(txItem_t)) txFifo (
		.CLK(CLK), .RST(RST), .push(txPush), .din(txIn), .full(txFull),
		.pop(txPop), .dout(txHead), .empty(txEmpty)
	);

	uartWriter writer (
		.CLK(CLK), .RST(RST), .empty(writeEmpty), .pop(txPop), .item(txHead),
		.status(status), .busOut(busOut), .busOe(busOe), .wrn(wrn), .txPulse(txPulse)
	);

	// Host side
	echoRegs regs (
		.CLK(CLK), .RST(RST), .wbIn(wbIn), .wbOut(wbOut),
		.rxPulse(rxPulse), .txPulse(txPulse), .incr(incr)
	);

endmodule

// File: verification/tbClock.sv
`timescale 1ns/10ps

module tbClock (
	output logic CLK,
	output logic RST
);

	localparam int HalfPeriod  = 4;
	localparam int ResetCycles = 4;

	initial begin
		CLK = 1'b0;
		forever #HalfPeriod CLK = ~CLK;
	end

	// Release lands on a falling edge, away from the active edge
	initial begin
		RST = 1'b0;
		repeat (ResetCycles) @(posedge CLK);
		@(negedge CLK);
		RST = 1'b1;
	end

endmodule

// File: verification/echoBus_chk.sv
`timescale 1ns/10ps

module echoBus_chk import echoPkg::*; (
	input logic   CLK,
	input logic   RST,
	input logic   rdn,
	input logic   wrn,
	input logic   busOe,
	input wbReq_t wbIn,
	input wbRsp_t wbOut
);

	////////////////////////////////////////////////////////////////////////////
	// Chip bus strobes
	////////////////////////////////////////////////////////////////////////////

	assert property (@(posedge CLK) disable iff (!RST) rdn || wrn)
		else $error("rdn and wrn low in the same cycle");

	// Data only driven inside the write strobe
	assert property (@(posedge CLK) disable iff (!RST) busOe |-> !wrn)
		else $error("busOe high while wrn is high");

	////////////////////////////////////////////////////////////////////////////
	// Wishbone classic slave
	////////////////////////////////////////////////////////////////////////////

	assert property (@(posedge CLK) disable iff (!RST) wbOut.ack |-> (wbIn.cyc && wbIn.stb))
		else $error("ack without cyc and stb");

	assert property (@(posedge CLK) disable iff (!RST) wbOut.ack |=> !wbOut.ack)
		else $error("ack held for two cycles");

endmodule

bind echoTop echoBus_chk chk (
	.CLK(CLK), .RST(RST), .rdn(rdn), .wrn(wrn), .busOe(busOe),
	.wbIn(wbIn), .wbOut(wbOut)
);

// File: verification/echoTb.sv
`timescale 1ns/10ps

module echoTb
	import uartBusPkg::*, echoPkg::*;
();

	localparam int ShortStallBits = 2;
	localparam int LongStallBits  = 5;
	localparam int LongStallBase  = 16;
	localparam int MaxStall       = LongStallBase + (1 << LongStallBits) - 1;
	localparam int PlainBytes     = 16;
	localparam int IncrBytes      = 8;
	localparam int FloodBytes     = 20;
	localparam int TotalBytes     = PlainBytes + IncrBytes + FloodBytes;
	// Worst case per byte is both stalls plus a margin, then room for register accesses
	localparam int CycleLimit     = TotalBytes * (2 * MaxStall + 64) + 200;

	logic        CLK;
	logic        RST;
	chipStatus_t status = '{dataReady: 1'b0, tbre: 1'b1, tsre: 1'b1};
	busByte_t    busIn  = 8'h00;
	busByte_t    busOut;
	logic        busOe;
	logic        rdn;
	logic        wrn;
	wbReq_t      wbIn   = '0;
	wbRsp_t      wbOut;

	// Receiver queue of the chip, expected echoes, bytes written back
	busByte_t    sendQ[$];
	busByte_t    expQ[$];
	busByte_t    recQ[$];

	logic [15:0] byteLfsr   = 16'd46010;
	logic [15:0] stallLfsr  = 16'd46010;
	logic        longStall  = 1'b0;
	logic        rdnPrev    = 1'b1;
	logic        wrnPrev    = 1'b1;
	int          tbreLeft   = 0;
	int          tsreLeft   = 0;
	busByte_t    latched    = 8'h00;
	busByte_t    gotByte;
	busByte_t    curIncr    = IncrReset;
	int          sent       = 0;
	int          checked    = 0;
	int          errors     = 0;
	int          errAtStart = 0;
	int          tests      = 0;
	int          failedTests = 0;
	int          cycles     = 0;

	tbClock clkGen (.CLK(CLK), .RST(RST));

	echoTop dut (
		.CLK(CLK), .RST(RST), .status(status), .busIn(busIn), .busOut(busOut),
		.busOe(busOe), .rdn(rdn), .wrn(wrn), .wbIn(wbIn), .wbOut(wbOut)
	);

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// Galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsrStep(logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic drawBits(input int n, inout logic [15:0] s, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(s[0]);
			s = lfsrStep(s);
		end
	endtask

	function automatic busByte_t expectedEcho(busByte_t b, busByte_t inc);
		return busByte_t'((int'(b) + int'(inc)) % 256);
	endfunction

	task automatic sendByte(busByte_t b);
		sendQ.push_back(b);
		expQ.push_back(expectedEcho(b, curIncr));
		sent++;
	endtask

	task automatic sendRandom(int n);
		int v;
		for (int i = 0; i < n; i++) begin
			drawBits(8, byteLfsr, v);
			sendByte(busByte_t'(v));
		end
	endtask

	// Every echo back and the chip idle again, then the txPulse settles
	task automatic waitDrained();
		while (checked < sent || tbreLeft > 0 || tsreLeft > 0) @(negedge CLK);
		repeat (4) @(negedge CLK);
	endtask

	task automatic wbWrite(logic [1:0] adr, logic [7:0] dat);
		@(negedge CLK);
		wbIn = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
		@(negedge CLK);
		while (!wbOut.ack) @(negedge CLK);
		// Hold through the edge that ends the ack cycle
		@(negedge CLK);
		wbIn = '0;
	endtask

	task automatic wbRead(input logic [1:0] adr, output logic [7:0] dat);
		@(negedge CLK);
		wbIn = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 8'h00};
		@(negedge CLK);
		while (!wbOut.ack) @(negedge CLK);
		dat = wbOut.dat;
		@(negedge CLK);
		wbIn = '0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic checkByte(busByte_t got, busByte_t exp, string what);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s was %02h, expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic checkReg(logic [7:0] got, logic [7:0] exp, string what);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s read %02h, expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic checkPin(logic got, logic exp, string what);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s was %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic expectReg(logic [1:0] adr, logic [7:0] exp, string what);
		logic [7:0] dat;
		wbRead(adr, dat);
		checkReg(dat, exp, what);
	endtask

	task automatic endTest(string name);
		tests++;
		if (errors == errAtStart) begin
			$display("Test %0d %s: ok", tests, name);
		end else begin
			failedTests++;
			$display("Test %0d %s: failed with %0d errors", tests, name, errors - errAtStart);
		end
		errAtStart = errors;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// UART chip model
	////////////////////////////////////////////////////////////////////////////

	always @(negedge CLK) begin
		// Receive side, byte leaves the chip when rdn rises
		if (rdn && !rdnPrev && sendQ.size() > 0) begin
			void'(sendQ.pop_front());
		end
		rdnPrev = rdn;
		status.dataReady = (sendQ.size() > 0);
		busIn = (!rdn && sendQ.size() > 0) ? sendQ[0] : 8'h00;

		// Transmit side
		if (!wrn) begin
			latched = busOut;
		end
		if (wrn && !wrnPrev) begin
			recQ.push_back(latched);
			if (longStall) begin
				drawBits(LongStallBits, stallLfsr, tbreLeft);
				drawBits(LongStallBits, stallLfsr, tsreLeft);
				tbreLeft += LongStallBase;
				tsreLeft += LongStallBase;
			end else begin
				drawBits(ShortStallBits, stallLfsr, tbreLeft);
				drawBits(ShortStallBits, stallLfsr, tsreLeft);
			end
		end
		wrnPrev = wrn;
		if (tbreLeft > 0) begin
			tbreLeft--;
			status.tbre = 1'b0;
			status.tsre = 1'b0;
		end else if (tsreLeft > 0) begin
			tsreLeft--;
			status.tbre = 1'b1;
			status.tsre = 1'b0;
		end else begin
			status.tbre = 1'b1;
			status.tsre = 1'b1;
		end
	end

	// In-order compare of every byte the DUT wrote
	always @(negedge CLK) begin
		if (recQ.size() > 0) begin
			gotByte = recQ.pop_front();
			if (expQ.size() == 0) begin
				errors++;
				$display("Extra byte %02h written by the DUT at %0t ns", gotByte, $time);
			end else begin
				checkByte(gotByte, expQ.pop_front(), "echoed byte");
			end
			checked++;
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= CycleLimit) begin
			$display("Timeout after %0d cycles, the echo stalled with %0d of %0d bytes back",
				cycles, checked, sent);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		$timeformat(-9, 0, "", 0);
		@(posedge RST);
		@(negedge CLK);

		checkPin(rdn, 1'b1, "rdn after reset");
		checkPin(wrn, 1'b1, "wrn after reset");
		checkPin(busOe, 1'b0, "busOe after reset");
		expectReg(RegIncr, IncrReset, "incr after reset");
		expectReg(RegRxCount, 8'd0, "rxCount after reset");
		expectReg(RegTxCount, 8'd0, "txCount after reset");
		endTest("reset state");

		// 0xFF in the middle checks the wrap
		sendRandom(7);
		sendByte(8'hFF);
		sendRandom(PlainBytes - 8);
		waitDrained();
		endTest("default increment");

		curIncr = 8'h5A;
		wbWrite(RegIncr, curIncr);
		expectReg(RegIncr, curIncr, "incr readback");
		wbWrite(RegRxCount, 8'hC3);
		expectReg(RegRxCount, 8'(sent), "rxCount after write");
		sendRandom(IncrBytes);
		waitDrained();
		endTest("new increment");

		longStall = 1'b1;
		sendRandom(FloodBytes);
		waitDrained();
		longStall = 1'b0;
		endTest("back-pressure");

		expectReg(RegRxCount, 8'(sent), "rxCount after traffic");
		expectReg(RegTxCount, 8'(sent), "txCount after traffic");
		endTest("byte counts");

		$display("Tests %0d, failed %0d, bytes %0d sent %0d compared, errors %0d",
			tests, failedTests, sent, checked, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: flist.f
hdl/uartBusPkg.sv
hdl/echoPkg.sv
hdl/uartReader.sv
hdl/stageFifo.sv
hdl/echoTransform.sv
hdl/echoRegs.sv
hdl/uartWriter.sv
hdl/echoTop.sv
verification/tbClock.sv
verification/echoBus_chk.sv
verification/echoTb.sv

// File: Makefile
SIM    := verilator
FLAGS  := --binary --timing --assert -Wno-fatal
TOP    := echoTb
FLIST  := flist.f
OBJDIR := obj_dir
LOG    := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)
	@./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" $(LOG) || \
	   ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
